//--- common/matInvPkg.sv
`default_nettype none

package matInvPkg;

	// matrix geometry
	localparam int order = 5;
	localparam int augCols = 2 * order;

	// row steps in one full reduction
	localparam int stepCount = 20;

	typedef logic [2:0] rowIdx_t;
	typedef logic [4:0] stepIdx_t;

	//////////////////////////////
	// elimination plan
	//////////////////////////////

	// first ten steps clear below the diagonal, last ten clear above it
	localparam rowIdx_t pivotPlan [stepCount] = '{
		3'd0, 3'd0, 3'd0, 3'd0, 3'd1,
		3'd1, 3'd1, 3'd2, 3'd2, 3'd3,
		3'd4, 3'd4, 3'd4, 3'd4, 3'd3,
		3'd3, 3'd3, 3'd2, 3'd2, 3'd1
	};

	localparam rowIdx_t targetPlan [stepCount] = '{
		3'd1, 3'd2, 3'd3, 3'd4, 3'd2,
		3'd3, 3'd4, 3'd3, 3'd4, 3'd4,
		3'd3, 3'd2, 3'd1, 3'd0, 3'd2,
		3'd1, 3'd0, 3'd1, 3'd0, 3'd0
	};

endpackage

`default_nettype wire

//--- hdl/matrixLoader.sv
`timescale 1ns/1ps
`default_nettype none

module matrixLoader #(
	parameter int dataWidth = 64
) (
	input wire clk,
	input wire rstN,
	input wire entryValid,
	input wire [dataWidth-1:0] entryData,
	input wire elimBusy,
	output logic loadBusy,
	output logic augValid,
	output logic [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] augMatrix
);

	localparam matInvPkg::rowIdx_t lastIdx = matInvPkg::rowIdx_t'(matInvPkg::order - 1);

	matInvPkg::rowIdx_t rowCnt;
	matInvPkg::rowIdx_t colCnt;
	logic accept;
	logic lastEntry;

	assign accept = entryValid && !loadBusy;
	assign lastEntry = (rowCnt == lastIdx) && (colCnt == lastIdx);

	// hand the full matrix over once the engine is free
	assign augValid = loadBusy && !elimBusy;

	//////////////////////////////
	// entry position and busy
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			loadBusy <= 1'b0;
			rowCnt <= '0;
			colCnt <= '0;
		end
		else if (accept)
		begin
			if (colCnt == lastIdx)
			begin
				colCnt <= '0;
				rowCnt <= lastEntry ? '0 : rowCnt + 1'b1;
			end
			else
			begin
				colCnt <= colCnt + 1'b1;
			end
			if (lastEntry)
				loadBusy <= 1'b1;
		end
		else if (augValid)
		begin
			loadBusy <= 1'b0;
		end
	end

	// left half from the stream, identity half on completion
	always_ff @(posedge clk)
	begin
		if (accept)
			augMatrix[rowCnt][colCnt] <= entryData;
		if (accept && lastEntry)
		begin
			for (int r = 0; r < matInvPkg::order; r++)
			begin
				for (int c = 0; c < matInvPkg::order; c++)
					augMatrix[r][matInvPkg::order + c] <= (r == c) ? dataWidth'(1) : '0;
			end
		end
	end

	// engine picks up the matrix on the handoff cycle
	handoffTaken: assert property (@(posedge clk) disable iff (!rstN)
		augValid |=> elimBusy);

endmodule

`default_nettype wire

//--- elim/rowCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module rowCombiner #(
	parameter int dataWidth = 64
) (
	input wire [matInvPkg::augCols-1:0][dataWidth-1:0] pivotRow,
	input wire [matInvPkg::augCols-1:0][dataWidth-1:0] targetRow,
	input wire matInvPkg::rowIdx_t pivotCol,
	output logic [matInvPkg::augCols-1:0][dataWidth-1:0] newPivotRow,
	output logic [matInvPkg::augCols-1:0][dataWidth-1:0] newTargetRow
);

	logic [dataWidth-1:0] pivotElem;
	logic [dataWidth-1:0] targetElem;

	// the two entries in the pivot column
	assign pivotElem = pivotRow[pivotCol];
	assign targetElem = targetRow[pivotCol];

	//////////////////////////////
	// cross multiply, subtract
	//////////////////////////////

	// all products and differences wrap at dataWidth
	always_comb
	begin
		for (int c = 0; c < matInvPkg::augCols; c++)
		begin
			newPivotRow[c] = pivotRow[c] * targetElem;
			newTargetRow[c] = (targetRow[c] * pivotElem) - (pivotRow[c] * targetElem);
		end
	end

endmodule

`default_nettype wire

//--- elim/eliminationEngine.sv
`timescale 1ns/1ps
`default_nettype none

module eliminationEngine #(
	parameter int dataWidth = 64
) (
	input wire clk,
	input wire rstN,
	input wire augValid,
	input wire [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] augMatrix,
	input wire unloadBusy,
	output logic elimBusy,
	output logic redValid,
	output logic [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] redMatrix
);

	localparam matInvPkg::stepIdx_t lastStep = matInvPkg::stepIdx_t'(matInvPkg::stepCount);

	logic [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] work;
	logic [matInvPkg::augCols-1:0][dataWidth-1:0] newPivotRow;
	logic [matInvPkg::augCols-1:0][dataWidth-1:0] newTargetRow;
	matInvPkg::stepIdx_t stepIdx;
	matInvPkg::stepIdx_t planIdx;
	matInvPkg::rowIdx_t pivotIdx;
	matInvPkg::rowIdx_t targetIdx;
	logic running;
	logic skipStep;

	//////////////////////////////
	// plan lookup
	//////////////////////////////

	assign running = elimBusy && (stepIdx != lastStep);

	// keep the table index in range once the plan is done
	assign planIdx = running ? stepIdx : '0;
	assign pivotIdx = matInvPkg::pivotPlan[planIdx];
	assign targetIdx = matInvPkg::targetPlan[planIdx];

	// column is the pivot row number
	assign skipStep = (work[targetIdx][pivotIdx] == '0);

	rowCombiner #(
		.dataWidth(dataWidth)
	) combiner (
		.pivotRow(work[pivotIdx]),
		.targetRow(work[targetIdx]),
		.pivotCol(pivotIdx),
		.newPivotRow(newPivotRow),
		.newTargetRow(newTargetRow)
	);

	//////////////////////////////
	// step control
	//////////////////////////////

	assign redValid = elimBusy && !running && !unloadBusy;
	assign redMatrix = work;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			elimBusy <= 1'b0;
			stepIdx <= '0;
		end
		else if (augValid)
		begin
			elimBusy <= 1'b1;
			stepIdx <= '0;
		end
		else if (redValid)
		begin
			elimBusy <= 1'b0;
		end
		else if (running)
		begin
			stepIdx <= stepIdx + 1'b1;
		end
	end

	// one pivot/target pair per cycle while skipped steps only advance the counter
	always_ff @(posedge clk)
	begin
		if (augValid)
		begin
			work <= augMatrix;
		end
		else if (running && !skipStep)
		begin
			work[pivotIdx] <= newPivotRow;
			work[targetIdx] <= newTargetRow;
		end
	end

	// a new matrix never lands on a reduction in progress
	noOverwrite: assert property (@(posedge clk) disable iff (!rstN)
		augValid |-> !elimBusy);

	// unloader takes the matrix and the engine frees up together
	cleanHandoff: assert property (@(posedge clk) disable iff (!rstN)
		redValid |-> !unloadBusy ##1 (unloadBusy && !elimBusy));

endmodule

`default_nettype wire

//--- hdl/resultUnloader.sv
`timescale 1ns/1ps
`default_nettype none

module resultUnloader #(
	parameter int dataWidth = 64
) (
	input wire clk,
	input wire rstN,
	input wire redValid,
	input wire [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] redMatrix,
	output logic unloadBusy,
	output logic resultValid,
	output logic [dataWidth-1:0] resultData,
	output logic resultLast,
	output logic [dataWidth-1:0] detA
);

	localparam matInvPkg::rowIdx_t lastIdx = matInvPkg::rowIdx_t'(matInvPkg::order - 1);

	logic [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] held;
	logic [dataWidth-1:0] detAcc;
	matInvPkg::rowIdx_t resRow;
	matInvPkg::rowIdx_t resCol;

	//////////////////////////////
	// output stream
	//////////////////////////////

	// one beat per cycle for the whole busy window
	assign resultValid = unloadBusy;
	assign resultData = held[resRow][int'(resCol) + matInvPkg::order];
	assign resultLast = unloadBusy && (resRow == lastIdx) && (resCol == lastIdx);
	assign detA = detAcc;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			unloadBusy <= 1'b0;
			resRow <= '0;
			resCol <= '0;
		end
		else if (redValid)
		begin
			unloadBusy <= 1'b1;
			resRow <= '0;
			resCol <= '0;
		end
		else if (unloadBusy)
		begin
			if (resCol == lastIdx)
			begin
				resCol <= '0;
				resRow <= (resRow == lastIdx) ? '0 : resRow + 1'b1;
			end
			else
			begin
				resCol <= resCol + 1'b1;
			end
			if (resultLast)
				unloadBusy <= 1'b0;
		end
	end

	//////////////////////////////
	// capture and determinant
	//////////////////////////////

	// diagonal product builds up while row 0 is streaming
	always_ff @(posedge clk)
	begin
		if (redValid)
		begin
			held <= redMatrix;
			detAcc <= dataWidth'(1);
		end
		else if (unloadBusy && (resRow == '0))
		begin
			detAcc <= detAcc * held[resCol][resCol];
		end
	end

endmodule

`default_nettype wire

//--- hdl/matrixInverter.sv
`timescale 1ns/1ps
`default_nettype none

module matrixInverter #(
	parameter int dataWidth = 64
) (
	input wire clk,
	input wire rstN,
	input wire entryValid,
	input wire [dataWidth-1:0] entryData,
	output logic loadBusy,
	output logic resultValid,
	output logic [dataWidth-1:0] resultData,
	output logic resultLast,
	output logic [dataWidth-1:0] detA
);

	//////////////////////////////
	// stage links
	//////////////////////////////

	// loader to engine
	logic augValid;
	logic elimBusy;
	logic [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] augMatrix;

	// engine to unloader
	logic redValid;
	logic unloadBusy;
	logic [matInvPkg::order-1:0][matInvPkg::augCols-1:0][dataWidth-1:0] redMatrix;

	matrixLoader #(
		.dataWidth(dataWidth)
	) loader (
		.clk(clk),
		.rstN(rstN),
		.entryValid(entryValid),
		.entryData(entryData),
		.elimBusy(elimBusy),
		.loadBusy(loadBusy),
		.augValid(augValid),
		.augMatrix(augMatrix)
	);

	eliminationEngine #(
		.dataWidth(dataWidth)
	) engine (
		.clk(clk),
		.rstN(rstN),
		.augValid(augValid),
		.augMatrix(augMatrix),
		.unloadBusy(unloadBusy),
		.elimBusy(elimBusy),
		.redValid(redValid),
		.redMatrix(redMatrix)
	);

	resultUnloader #(
		.dataWidth(dataWidth)
	) unloader (
		.clk(clk),
		.rstN(rstN),
		.redValid(redValid),
		.redMatrix(redMatrix),
		.unloadBusy(unloadBusy),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultLast(resultLast),
		.detA(detA)
	);

endmodule

`default_nettype wire

//--- verif/invRefModel.svh
`ifndef INV_REF_MODEL_SVH
`define INV_REF_MODEL_SVH
`default_nettype none

// expected right half (row-major) and diagonal product for one input matrix
function automatic void invReference(
	input logic [n*n-1:0][dataWidth-1:0] entries,
	output logic [n*n-1:0][dataWidth-1:0] expInv,
	output logic [dataWidth-1:0] expDet
);
	logic [dataWidth-1:0] m [n][2*n];
	logic [dataWidth-1:0] pv;
	logic [dataWidth-1:0] tv;
	int p;
	int t;
	// left half from the input, identity on the right
	for (int r = 0; r < n; r++)
		for (int c = 0; c < 2 * n; c++)
			m[r][c] = (c < n) ? entries[r*n + c] : ((c - n == r) ? dataWidth'(1) : '0);
	for (int s = 0; s < matInvPkg::stepCount; s++)
	begin
		p = int'(matInvPkg::pivotPlan[s]);
		t = int'(matInvPkg::targetPlan[s]);
		tv = m[t][p];
		pv = m[p][p];
		// nothing to clear when the target is already zero
		if (tv != '0)
		begin
			for (int c = 0; c < 2 * n; c++)
			begin
				m[p][c] = m[p][c] * tv;
				m[t][c] = m[t][c] * pv - m[p][c];
			end
		end
	end
	expDet = dataWidth'(1);
	for (int r = 0; r < n; r++)
	begin
		expDet = expDet * m[r][r];
		for (int c = 0; c < n; c++)
			expInv[r*n + c] = m[r][n + c];
	end
endfunction

`default_nettype wire
`endif

//--- verif/matrixInverterTb.sv
`timescale 1ns/1ps
`default_nettype none

module matrixInverterTb;

	localparam int dataWidth = 64;
	localparam int n = matInvPkg::order;
	localparam int cells = n * n;
	localparam int matrixTotal = 21;
	localparam int cycleLimit = matrixTotal * (25 + 20 + 25) + 200;

	// worked example with small entries
	localparam int exampleVals [cells] = '{
		2, 1, 0, 3, 1,
		1, 3, 2, 0, 4,
		0, 2, 5, 1, 1,
		3, 0, 1, 4, 2,
		1, 4, 1, 2, 3
	};

	logic clk;
	logic rstN;
	logic entryValid;
	logic [dataWidth-1:0] entryData;
	logic loadBusy;
	logic resultValid;
	logic [dataWidth-1:0] resultData;
	logic resultLast;
	logic [dataWidth-1:0] detA;

	logic [dataWidth-1:0] stimQ [$];
	logic [dataWidth-1:0] accQ [$];
	logic [dataWidth-1:0] expQ [$];
	logic [dataWidth-1:0] detQ [$];
	logic [cells-1:0][dataWidth-1:0] accMatrix;
	logic [cells-1:0][dataWidth-1:0] refInv;
	logic [dataWidth-1:0] refDet;
	logic [dataWidth-1:0] expVal;
	logic [dataWidth-1:0] lastDet;
	integer seed;
	int cycles = 0;
	int acceptTotal = 0;
	int ignoredTotal = 0;
	int beatCount = 0;
	int doneCount = 0;
	int checkErrs = 0;
	int stepErrs = 0;
	int testCount = 0;
	int failedTests = 0;

	matrixInverter #(
		.dataWidth(dataWidth)
	) uut (
		.clk(clk),
		.rstN(rstN),
		.entryValid(entryValid),
		.entryData(entryData),
		.loadBusy(loadBusy),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultLast(resultLast),
		.detA(detA)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("run stopped after %0d cycles with results still pending", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////
	// accept monitor and checker
	//////////////////////////////

	// sampled mid-cycle when inputs and outputs have settled
	always @(negedge clk)
	begin
		if (!rstN)
		begin
			accQ.delete();
			expQ.delete();
			detQ.delete();
			beatCount = 0;
		end
		else
		begin
			if (entryValid && loadBusy)
				ignoredTotal++;
			if (entryValid && !loadBusy)
			begin
				accQ.push_back(entryData);
				acceptTotal++;
				if (accQ.size() == cells)
				begin
					for (int i = 0; i < cells; i++)
						accMatrix[i] = accQ[i];
					accQ.delete();
					invReference(accMatrix, refInv, refDet);
					for (int i = 0; i < cells; i++)
						expQ.push_back(refInv[i]);
					detQ.push_back(refDet);
				end
			end
			if (resultValid)
			begin
				beatCount++;
				if (expQ.size() == 0)
				begin
					$display("result beat arrived with no matrix pending");
					checkErrs++;
				end
				else
				begin
					expVal = expQ.pop_front();
					if (resultData !== expVal)
					begin
						$display("Error resultData: got %h, expected %h", resultData, expVal);
						checkErrs++;
					end
				end
				if (resultLast)
				begin
					if (beatCount != cells)
					begin
						$display("matrix ended after %0d beats instead of %0d", beatCount, cells);
						checkErrs++;
					end
					lastDet = detA;
					if (detQ.size() > 0)
					begin
						expVal = detQ.pop_front();
						if (detA !== expVal)
						begin
							$display("Error detA: got %h, expected %h", detA, expVal);
							checkErrs++;
						end
					end
					beatCount = 0;
					doneCount++;
				end
			end
		end
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// holds each entry until the loader takes it
	task automatic driveStream();
		logic taken;
		entryValid <= 1'b1;
		entryData <= stimQ[0];
		while (stimQ.size() > 0)
		begin
			@(negedge clk);
			taken = !loadBusy;
			@(posedge clk);
			if (taken)
			begin
				stimQ.delete(0);
				if (stimQ.size() > 0)
					entryData <= stimQ[0];
				else
					entryValid <= 1'b0;
			end
		end
	endtask

	task automatic queueRandom(input int span);
		for (int i = 0; i < cells; i++)
			stimQ.push_back(dataWidth'($unsigned($random(seed)) % span));
	endtask

	task automatic waitDone(input int target);
		while (doneCount < target)
			@(posedge clk);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (checkErrs + stepErrs == errBefore)
			$display("%s: ok", name);
		else
		begin
			failedTests++;
			$display("%s: %0d errors", name, checkErrs + stepErrs - errBefore);
		end
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial
	begin
		int errBefore;
		int target;
		int stopAt;
		int ignoredBefore;
		seed = 32'h82a5_7ffd;
		rstN = 1'b0;
		entryValid = 1'b0;
		entryData = '0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		errBefore = checkErrs + stepErrs;
		target = doneCount + 1;
		for (int i = 0; i < cells; i++)
			stimQ.push_back((i % (n + 1) == 0) ? dataWidth'(1) : '0);
		driveStream();
		waitDone(target);
		if (lastDet !== dataWidth'(1))
		begin
			$display("Error detA: got %h, expected %h", lastDet, dataWidth'(1));
			stepErrs++;
		end
		reportTest("identity matrix", errBefore);

		errBefore = checkErrs + stepErrs;
		target = doneCount + 1;
		for (int i = 0; i < cells; i++)
			stimQ.push_back(dataWidth'(exampleVals[i]));
		driveStream();
		waitDone(target);
		reportTest("example matrix", errBefore);

		// entries 0 to 3 hit zero targets and wrap quickly
		errBefore = checkErrs + stepErrs;
		for (int k = 0; k < 12; k++)
		begin
			target = doneCount + 1;
			queueRandom(4);
			driveStream();
			waitDone(target);
		end
		reportTest("random small matrices", errBefore);

		errBefore = checkErrs + stepErrs;
		target = doneCount + 3;
		repeat (3) queueRandom(16);
		driveStream();
		waitDone(target);
		reportTest("back-to-back matrices", errBefore);

		// new data every cycle so that some of it arrives while the loader is busy
		errBefore = checkErrs + stepErrs;
		target = doneCount + 2;
		stopAt = acceptTotal + 2 * cells;
		ignoredBefore = ignoredTotal;
		entryValid <= 1'b1;
		entryData <= dataWidth'($unsigned($random(seed)) % 16);
		while (acceptTotal < stopAt)
		begin
			@(posedge clk);
			if (acceptTotal < stopAt)
				entryData <= dataWidth'($unsigned($random(seed)) % 16);
			else
				entryValid <= 1'b0;
		end
		waitDone(target);
		if (ignoredTotal == ignoredBefore)
		begin
			$display("no entry was presented while the loader was busy");
			stepErrs++;
		end
		reportTest("entries while busy", errBefore);

		errBefore = checkErrs + stepErrs;
		queueRandom(4);
		driveStream();
		while (beatCount < 10)
			@(posedge clk);
		rstN <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		if (resultValid || resultLast || loadBusy)
		begin
			$display("Error resultValid %h resultLast %h loadBusy %h, expected 0 after reset",
				resultValid, resultLast, loadBusy);
			stepErrs++;
		end
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		target = doneCount + 1;
		queueRandom(4);
		driveStream();
		waitDone(target);
		reportTest("reset during result stream", errBefore);

		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests,
			checkErrs + stepErrs);
		if (checkErrs + stepErrs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

`include "invRefModel.svh"

endmodule

`default_nettype wire

//--- sim.f
+incdir+verif
common/matInvPkg.sv
hdl/matrixLoader.sv
elim/rowCombiner.sv
elim/eliminationEngine.sv
hdl/resultUnloader.sv
hdl/matrixInverter.sv
verif/matrixInverterTb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module matrixInverterTb -o simv \
	&& ./obj_dir/simv | tee sim.log \
	|| echo "build or simulation did not complete"
grep -qx "Regression passed" sim.log \
	&& echo "PASS" \
	&& exit 0 \
	|| { echo "FAIL"; exit 1; }
